//--- hw/fir_pkg.sv
// ================================================
// Shared dimensions, arithmetic constants and bus
// types of the block-parallel symmetric FIR filter.
// Modules refer to these by scoped names only.
// ================================================

`default_nettype none

package fir_pkg;

    // Filter dimensions
    localparam int K_TAPS    = 8;                    // Must be even
    localparam int N_LANES   = 16;                   // Samples per block
    localparam int D_BITS    = 12;
    localparam int M_BITS    = 16;
    localparam int N_COEF    = K_TAPS / 2;
    localparam int HIST_LEN  = K_TAPS - 1;
    localparam int WIN_LEN   = N_LANES + HIST_LEN;

    // ================================================
    // Arithmetic
    // ================================================
    // Pair sum adds one bit, product adds M_BITS, the N_COEF-term sum adds the rest
    localparam int ACC_BITS  = D_BITS + 1 + M_BITS + $clog2(N_COEF);
    localparam int COEF_FRAC = 15;
    localparam int D_MAX     = (2 ** (D_BITS - 1)) - 1;
    localparam int D_MIN     = -(2 ** (D_BITS - 1));

    // Stream gap handling
    localparam int GAP_LIMIT = 8;
    localparam int GAP_W     = $clog2(GAP_LIMIT + 1);

    // Coefficient bus
    localparam int WB_AW     = $clog2(N_COEF);

    typedef logic signed [D_BITS-1:0] sample_t;
    typedef logic signed [M_BITS-1:0] coef_t;

    typedef sample_t [N_LANES-1:0] sample_blk_t;    // Index 0 oldest
    typedef sample_t [WIN_LEN-1:0] window_t;        // History low, new block high
    typedef coef_t   [N_COEF-1:0]  coef_set_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [WB_AW-1:0]  adr;
        logic [M_BITS-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [M_BITS-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- hw/fir_coef_regs.sv
// ================================================
// Wishbone classic slave holding the unique FIR
// coefficients. Ack follows a strobe by one cycle,
// writes land on the ack edge.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module fir_coef_regs (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  fir_pkg::wb_req_t    wb_i,
    output fir_pkg::wb_rsp_t    wb_o,
    output fir_pkg::coef_set_t  coef_o
);

    logic                        ack_q;
    logic                        cycle_start;
    logic [fir_pkg::M_BITS-1:0]  rdat_q;
    fir_pkg::coef_set_t          coef_q;

    // Fresh strobe, ack not yet given
    assign cycle_start = wb_i.cyc & wb_i.stb & ~ack_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            coef_q <= '0;
        end else begin
            ack_q <= cycle_start;                     // One-cycle pulse
            if (cycle_start && wb_i.we) begin
                coef_q[wb_i.adr] <= wb_i.dat;
            end
        end
    end

    // Read data held for the ack cycle
    always_ff @(posedge clk_i) begin
        if (cycle_start) begin
            rdat_q <= coef_q[wb_i.adr];
        end
    end

    always_comb begin
        wb_o.ack = ack_q;
        wb_o.dat = rdat_q;
    end

    assign coef_o = coef_q;

endmodule

`default_nettype wire

//--- hw/fir_ctrl_fsm.sv
// ================================================
// Priming and run control. Forms the input ready,
// clears history on a stream gap and delays the
// output valid to the datapath latency.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module fir_ctrl_fsm (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic data_vld_i,
    input  logic wr_strobe_i,
    input  logic gap_i,
    output logic accept_o,
    output logic hist_clr_o,
    output logic run_o,
    output logic data_rdy_o,
    output logic data_vld_o
);

    typedef enum logic {
        IDLE,       // History empty
        RUN         // History holds real samples
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic       rdy_q;                              // Low until reset released
    logic [1:0] vld_pipe;

    // No block may straddle a coefficient write
    assign data_rdy_o = rdy_q & ~wr_strobe_i;
    assign accept_o   = data_vld_i & data_rdy_o;

    assign run_o      = (state == RUN);
    assign hist_clr_o = (state == RUN) & gap_i;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept_o) begin
                    state_nxt = RUN;                // Priming block
                end
            end
            RUN: begin
                if (gap_i) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // ================================================
    // State and valid pipeline
    // ================================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= IDLE;
            rdy_q    <= 1'b0;
            vld_pipe <= 2'b00;
        end else begin
            state    <= state_nxt;
            rdy_q    <= 1'b1;
            // Window stage then tap stage
            vld_pipe <= {vld_pipe[0], accept_o & (state == RUN)};
        end
    end

    assign data_vld_o = vld_pipe[1];

endmodule

`default_nettype wire

//--- hw/fir_gap_timer.sv
// ================================================
// Idle cycle counter for the input stream. Pulses
// gap_o on the GAP_LIMIT-th idle cycle in a row
// while the filter is running.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module fir_gap_timer (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic run_i,
    input  logic accept_i,
    output logic gap_o
);

    logic [fir_pkg::GAP_W-1:0] idle_cnt;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idle_cnt <= '0;
        end else if (!run_i || accept_i) begin
            idle_cnt <= '0;                                 // Reload
        end else if (idle_cnt != fir_pkg::GAP_W'(fir_pkg::GAP_LIMIT)) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // Count reaches GAP_LIMIT at the end of this cycle
    assign gap_o = run_i & ~accept_i
                 & (idle_cnt == fir_pkg::GAP_W'(fir_pkg::GAP_LIMIT - 1));

endmodule

`default_nettype wire

//--- hw/fir_window_buf.sv
// ================================================
// Sample history and working window. Each accepted
// block is registered behind the last HIST_LEN
// samples of the block before it.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module fir_window_buf (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  accept_i,
    input  logic                  hist_clr_i,
    input  fir_pkg::sample_blk_t  blk_i,
    output fir_pkg::window_t      win_o
);

    localparam int LAST = fir_pkg::N_LANES - 1;
    localparam int KEEP = fir_pkg::N_LANES - fir_pkg::HIST_LEN;

    fir_pkg::sample_t [fir_pkg::HIST_LEN-1:0] hist_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist_q <= '0;
        end else if (hist_clr_i) begin
            hist_q <= '0;                       // Gap expired
        end else if (accept_i) begin
            hist_q <= blk_i[LAST:KEEP];         // Newest samples of the block
        end
    end

    // Oldest history at index 0
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            win_o <= {blk_i, hist_q};
        end
    end

endmodule

`default_nettype wire

//--- hw/fir_sym_tap.sv
// ================================================
// One output lane. Mirrored samples are pre-added,
// scaled by the unique coefficients, shifted down
// by COEF_FRAC, saturated and registered.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module fir_sym_tap (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  fir_pkg::sample_t [fir_pkg::K_TAPS-1:0] taps_i,
    input  fir_pkg::coef_set_t                     coef_i,
    output logic signed [fir_pkg::D_BITS-1:0]      y_o
);

    localparam int PS_BITS = fir_pkg::D_BITS + 1;
    localparam int PR_BITS = PS_BITS + fir_pkg::M_BITS;

    logic signed [PS_BITS-1:0]           pair_sum [fir_pkg::N_COEF];
    logic signed [PR_BITS-1:0]           prod     [fir_pkg::N_COEF];
    logic signed [fir_pkg::ACC_BITS-1:0] acc;
    logic signed [fir_pkg::ACC_BITS-1:0] acc_sh;
    logic signed [fir_pkg::D_BITS-1:0]   y_sat;

    always_comb begin
        acc = '0;
        for (int j = 0; j < fir_pkg::N_COEF; j++) begin
            pair_sum[j] = $signed(taps_i[j]) + $signed(taps_i[fir_pkg::K_TAPS-1-j]);
            prod[j]     = pair_sum[j] * $signed(coef_i[j]);
            acc         = acc + prod[j];
        end
    end

    // Arithmetic shift rounds toward minus infinity
    assign acc_sh = acc >>> fir_pkg::COEF_FRAC;

    always_comb begin
        if (acc_sh > fir_pkg::D_MAX) begin
            y_sat = fir_pkg::D_BITS'(fir_pkg::D_MAX);
        end else if (acc_sh < fir_pkg::D_MIN) begin
            y_sat = fir_pkg::D_BITS'(fir_pkg::D_MIN);
        end else begin
            y_sat = acc_sh[fir_pkg::D_BITS-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            y_o <= '0;
        end else begin
            y_o <= y_sat;
        end
    end

endmodule

`default_nettype wire

//--- hw/fir_top.sv
// ================================================
// Symmetric FIR filter, N_LANES samples per cycle.
// Samples enter on a valid/ready pair, coefficients
// are set over Wishbone, results follow 2 cycles on.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module fir_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  data_vld_i,
    input  fir_pkg::sample_blk_t  data_x_i,
    output logic                  data_rdy_o,
    output logic                  data_vld_o,
    output fir_pkg::sample_blk_t  data_y_o,
    input  fir_pkg::wb_req_t      wb_i,
    output fir_pkg::wb_rsp_t      wb_o
);

    fir_pkg::coef_set_t coef;
    fir_pkg::window_t   win;
    logic               wr_strobe;
    logic               accept;
    logic               hist_clr;
    logic               run;
    logic               gap;

    assign wr_strobe = wb_i.cyc & wb_i.stb & wb_i.we;

    fir_coef_regs u_coef_regs (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wb_i    (wb_i),
        .wb_o    (wb_o),
        .coef_o  (coef)
    );

    fir_ctrl_fsm u_ctrl_fsm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .data_vld_i  (data_vld_i),
        .wr_strobe_i (wr_strobe),
        .gap_i       (gap),
        .accept_o    (accept),
        .hist_clr_o  (hist_clr),
        .run_o       (run),
        .data_rdy_o  (data_rdy_o),
        .data_vld_o  (data_vld_o)
    );

    fir_gap_timer u_gap_timer (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .run_i    (run),
        .accept_i (accept),
        .gap_o    (gap)
    );

    fir_window_buf u_window_buf (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .accept_i   (accept),
        .hist_clr_i (hist_clr),
        .blk_i      (data_x_i),
        .win_o      (win)
    );

    // ================================================
    // Lane i sees window samples i to i+K_TAPS-1
    // ================================================
    for (genvar i = 0; i < fir_pkg::N_LANES; i++) begin : g_lane
        fir_sym_tap u_tap (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .taps_i  (win[i+fir_pkg::K_TAPS-1:i]),
            .coef_i  (coef),
            .y_o     (data_y_o[i])
        );
    end

endmodule

`default_nettype wire

//--- tb/fir_tb.sv
// ================================================
// Testbench for the symmetric FIR filter. Replays
// the golden record file on the sample and Wishbone
// ports and checks every output block against it.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module fir_tb;

    localparam int NL = fir_pkg::N_LANES;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 data_vld_i;
    logic                 data_rdy_o;
    logic                 data_vld_o;
    fir_pkg::sample_blk_t data_x_i;
    fir_pkg::sample_blk_t data_y_o;
    fir_pkg::wb_req_t     wb_i;
    fir_pkg::wb_rsp_t     wb_o;

    byte tags[$];                   // Record tags in file order
    int  vals[$];                   // Record fields, flattened
    int  exp_q[$];                  // Expected lanes, lane 0 first
    int  due_q[$];                  // Cycle at which each block must show
    int  cyc_cnt     = 0;
    int  cycle_limit = 100000;
    int  errors      = 0;
    int  last_accept = 0;

    fir_top uut (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .data_vld_i (data_vld_i),
        .data_x_i   (data_x_i),
        .data_rdy_o (data_rdy_o),
        .data_vld_o (data_vld_o),
        .data_y_o   (data_y_o),
        .wb_i       (wb_i),
        .wb_o       (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc_cnt++;
        if (cyc_cnt > cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cyc_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // ================================================
    // Output monitor
    // ================================================
    always @(negedge clk_i) begin : monitor
        int exp_v;
        int due;
        if (rst_n_i && data_vld_o) begin
            assert (due_q.size() != 0) else begin
                errors++;
                $display("ERROR @%0t: output block with no expected block", $time);
            end
            if (due_q.size() != 0) begin
                due = due_q.pop_front();
                assert (cyc_cnt == due) else begin
                    errors++;
                    $display("ERROR @%0t: output at cycle %0d, expected %0d", $time, cyc_cnt, due);
                end
                for (int l = 0; l < NL; l++) begin
                    exp_v = exp_q.pop_front();
                    assert ($signed(data_y_o[l]) == exp_v) else begin
                        errors++;
                        $display("ERROR @%0t: lane %0d got %0d, expected %0d",
                                 $time, l, $signed(data_y_o[l]), exp_v);
                    end
                end
            end
        end
    end

    task automatic load_records(input int fd);
        byte   tag;
        int    code;
        int    v;
        int    n;
        int    cycles;
        string line;
        cycles = 0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code == 1 && tag == "#") begin
                code = $fgets(line, fd);                // Comment line
            end else if (code == 1) begin
                case (tag)
                    "W", "R": n = 2;
                    "X", "Y": n = NL;
                    "G":      n = 1;
                    default: begin
                        n = 0;
                        errors++;
                        $display("Golden file holds an unknown record tag %c", tag);
                    end
                endcase
                if (n > 0) begin
                    tags.push_back(tag);
                end
                for (int k = 0; k < n; k++) begin
                    code = $fscanf(fd, " %d", v);
                    vals.push_back(v);
                end
                if (tag == "W" || tag == "R") cycles += 4;
                else if (tag == "X") cycles += 1;
                else if (tag == "G") cycles += v;
            end
        end
        cycle_limit = 2 * cycles + 100;
    endtask

    task automatic bus_access(input logic we, input int adr, input int dat);
        int waits;
        waits = 0;
        @(negedge clk_i);
        data_vld_i = 1'b0;
        wb_i.cyc   = 1'b1;
        wb_i.stb   = 1'b1;
        wb_i.we    = we;
        wb_i.adr   = fir_pkg::WB_AW'(adr);
        wb_i.dat   = we ? fir_pkg::M_BITS'(dat) : '0;
        do begin
            @(negedge clk_i);
            waits++;
            assert (data_rdy_o == !we) else begin        // Only a write strobe holds off samples
                errors++;
                $display("ERROR @%0t: data_rdy_o is %0b during bus %s",
                         $time, data_rdy_o, we ? "write" : "read");
            end
        end while (!wb_o.ack);
        assert (waits == 1) else begin
            errors++;
            $display("ERROR @%0t: ack came %0d cycles after the strobe, expected 1",
                     $time, waits);
        end
        assert (we || wb_o.dat == fir_pkg::M_BITS'(dat)) else begin
            errors++;
            $display("ERROR @%0t: read of coef %0d got %0d, expected %0d",
                     $time, adr, $signed(wb_o.dat), dat);
        end
        wb_i = '0;
        @(negedge clk_i);
        assert (!wb_o.ack) else begin                   // Ack is a single pulse
            errors++;
            $display("ERROR @%0t: ack held longer than one cycle", $time);
        end
    endtask

    task automatic send_block();
        @(negedge clk_i);
        for (int l = 0; l < NL; l++) begin
            data_x_i[l] = fir_pkg::D_BITS'(vals.pop_front());
        end
        data_vld_i = 1'b1;
        assert (data_rdy_o) else begin
            errors++;
            $display("ERROR @%0t: data_rdy_o low with no write active", $time);
        end
        last_accept = cyc_cnt + 1;
    endtask

    // Window and tap each add one register
    task automatic expect_block();
        due_q.push_back(last_accept + 1);
        repeat (NL) exp_q.push_back(vals.pop_front());
    endtask

    task automatic idle_cycles(input int n);
        if (n > 0) begin
            @(negedge clk_i);
            data_vld_i = 1'b0;
            repeat (n - 1) @(negedge clk_i);
        end
    endtask

    task automatic run_records();
        byte tag;
        int  a;
        int  d;
        while (tags.size() > 0) begin
            tag = tags.pop_front();
            case (tag)
                "W", "R": begin
                    a = vals.pop_front();
                    d = vals.pop_front();
                    bus_access(tag == "W", a, d);
                end
                "X":     send_block();
                "Y":     expect_block();
                "G":     idle_cycles(vals.pop_front());
                default: ;
            endcase
        end
    endtask

    initial begin : stimulus
        int fd;
        rst_n_i    = 1'b0;
        data_vld_i = 1'b0;
        data_x_i   = '0;
        wb_i       = '0;
        fd = $fopen("tb/fir_golden.txt", "r");
        if (fd == 0) begin
            $display("Golden file tb/fir_golden.txt could not be opened");
            $display("Testbench failed");
            $finish;
        end else begin
            load_records(fd);
            $fclose(fd);
            repeat (3) @(posedge clk_i);
            @(negedge clk_i);
            assert (!data_rdy_o && !data_vld_o && !wb_o.ack) else begin
                errors++;
                $display("ERROR @%0t: outputs not low during reset", $time);
            end
            rst_n_i = 1'b1;
            @(negedge clk_i);
            assert (data_rdy_o && !data_vld_o && !wb_o.ack) else begin
                errors++;
                $display("ERROR @%0t: wrong output levels after reset", $time);
            end
            run_records();
            @(negedge clk_i);
            data_vld_i = 1'b0;
            while (due_q.size() > 0) @(negedge clk_i);
            repeat (4) @(negedge clk_i);                // Catch stray outputs
            $display("Checks done with %0d errors", errors);
            if (errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/fir_golden.txt
# W addr value | R addr expected | X 16 samples | G idle cycles | Y 16 expected outputs
# Signed decimal values, lane 0 first
W 0 291
W 1 1110
W 2 4660
W 3 16384
R 0 291
R 1 1110
R 2 4660
R 3 16384
W 0 0
W 1 0
W 2 0
R 2 0
# Only coef 3 set to one half, y = floor((s3 + s4) / 2)
X 0 10 20 30 40 50 60 70 80 90 100 110 120 130 140 150
X -1 -4 -7 -10 -13 -16 -19 -22 -25 -28 -31 -34 -37 -40 -43 -46
Y 125 135 145 74 -3 -6 -9 -12 -15 -18 -21 -24 -27 -30 -33 -36
X 500 500 500 500 500 500 500 500 500 500 500 500 500 500 500 500
Y -39 -42 -45 227 500 500 500 500 500 500 500 500 500 500 500 500
# Short gap keeps history
G 5
X -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100
Y 500 500 500 200 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100
# Gap at the limit, next block primes again
G 8
X 300 300 300 300 300 300 300 300 300 300 300 300 300 300 300 300
X 1 3 5 7 9 11 13 15 17 19 21 23 25 27 29 31
Y 300 300 300 150 2 4 6 8 10 12 14 16 18 20 22 24
# Saturation with full scale coefficients
G 10
W 0 32767
W 1 32767
W 2 32767
W 3 32767
R 3 32767
X 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047
X 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047
Y 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047 2047
G 10
X -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048
X -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048
Y -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048 -2048

//--- filelist.f
hw/fir_pkg.sv
hw/fir_coef_regs.sv
hw/fir_ctrl_fsm.sv
hw/fir_gap_timer.sv
hw/fir_window_buf.sv
hw/fir_sym_tap.sv
hw/fir_top.sv
tb/fir_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FIR testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fir_tb \
    -f filelist.f \
    -o fir_sim

./obj_dir/fir_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
